// File: Makefile
# Verilator build and run of the interrupt block testbench

TOP = intr_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench, fails on a failing run"
	@echo "  clean  remove the Verilator build folder"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: flist.f
logic/intr_ctrl_pkg.sv
logic/intr_fmt_pkg.sv
logic/intr_chan_ram.sv
logic/intr_event_engine.sv
logic/intr_scan_counter.sv
logic/intr_restore_seq.sv
logic/intr_host_port.sv
logic/intr_top.sv
tb/tb_clkgen.sv
tb/intr_tb.sv

// File: logic/intr_chan_ram.sv
// Registered read, one cycle latency; a colliding read returns the old word, contents not reset
module intr_chan_ram
  import intr_fmt_pkg::*;
#(
  parameter int seg_b = 2,
  parameter int bit_b = 3
) (
  input  logic                   iclk,
  input  logic                   we,
  input  logic [seg_b+bit_b-1:0] waddr,
  input  intr_entry_t            wdata,
  input  logic [seg_b+bit_b-1:0] raddr,
  output intr_entry_t            rdata
);

  intr_entry_t mem [1 << (seg_b + bit_b)]; // One word per channel

  always_ff @(posedge iclk)
  begin
    if (we)
    begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr]; // Old data on collision
  end

endmodule

// File: logic/intr_ctrl_pkg.sv
// Opcode, host command and sequencer state encodings; codes outside the enums are illegal on the op bus
package intr_ctrl_pkg;

  ////////////////////
  // Engine operations

  typedef enum logic [2:0] {
    op_event      = 3'd0, // Alarm rule, sticky and masked status
    op_read       = 3'd1, // Entry unchanged
    op_set_en     = 3'd2, // int_en replaced by status_mask
    op_clr_sticky = 3'd3, // Sticky cleared under status_mask
    op_init       = 3'd4  // Entry written to zero
  } intr_opcode_e;

  // Host side commands
  typedef enum logic [1:0] {
    cmd_read       = 2'd0,
    cmd_set_en     = 2'd1,
    cmd_clr_sticky = 2'd2
  } host_cmd_e;

  // Restore sequencer
  typedef enum logic [2:0] {
    s_init, s_idle, s_read, s_wait, s_clear, s_set
  } seq_state_e;

endpackage

// File: logic/intr_event_engine.sv
// One op per clock, result at t+2, irq at t+3; ops with unlisted opcodes must never be sent
module intr_event_engine
  import intr_ctrl_pkg::*;
  import intr_fmt_pkg::*;
#(
  parameter int seg_b = 2,
  parameter int bit_b = 3
) (
  input  logic                   iclk,
  input  logic                   arst_n,
  input  logic                   op_valid,
  input  intr_op_t               op,
  input  intr_entry_t            ram_rdata,
  output logic                   ram_we,
  output logic [seg_b+bit_b-1:0] ram_waddr,
  output logic [seg_b+bit_b-1:0] ram_raddr,
  output intr_entry_t            ram_wdata,
  output logic                   res_valid,
  output intr_result_t           res,
  output logic                   irq
);

  localparam int aw    = seg_b + bit_b;
  localparam int seg_n = 1 << seg_b; // Segment words

  logic              s1_valid;  // RAM data arriving
  intr_op_t          s1_op;
  logic [aw-1:0]     s1_addr;
  logic              s2_valid;  // Writing
  intr_op_t          s2_op;
  logic [aw-1:0]     s2_addr;
  intr_entry_t       s2_entry;
  logic              s3_valid;  // Written last cycle
  logic [aw-1:0]     s3_addr;
  intr_entry_t       s3_entry;
  intr_entry_t       cur;       // Old entry after forwarding
  intr_entry_t       nxt;
  logic [flag_w-1:0] ev_status;
  logic [flag_w-1:0] ev_chg;
  logic [bit_max-1:0] seg_q [seg_n];
  logic [bit_max-1:0] seg_nxt;
  logic [seg_b-1:0]  s2_seg;
  logic [bit_b-1:0]  s2_bit;
  logic              irq_nxt;

  function automatic logic [seg_b+bit_b-1:0] chan_addr(intr_op_t o);
    return {o.seg[seg_b-1:0], o.bit_id[bit_b-1:0]};
  endfunction

  ////////////////////
  // Stage 0 and 1

  assign ram_raddr = chan_addr(op); // Read issued on accept
  assign s1_addr   = chan_addr(s1_op);

  // Newest write wins, s3 covers the read that collided with it
  always_comb
  begin
    cur = ram_rdata;
    if (s3_valid && (s3_addr == s1_addr))
    begin
      cur = s3_entry;
    end
    if (s2_valid && (s2_addr == s1_addr))
    begin
      cur = s2_entry;
    end
  end

  always_comb
  begin
    nxt       = cur;
    ev_status = (cur.status & ~s1_op.status_mask) | (s1_op.status & s1_op.status_mask);
    ev_chg    = (ev_status ^ cur.status) & s1_op.change_en; // Watched bits that moved
    case (s1_op.opcode)
      op_event:
      begin
        nxt.status = ev_status;
        nxt.sticky = cur.sticky | s1_op.sticky_req | ev_chg;
      end
      op_set_en:     nxt.int_en = s1_op.status_mask;
      op_clr_sticky: nxt.sticky = cur.sticky & ~s1_op.status_mask; // Write one to clear
      op_init:       nxt = '0;
      default:       nxt = cur; // Read keeps the entry
    endcase
  end

  ////////////////////
  // Stage 2

  assign s2_addr = chan_addr(s2_op);
  assign s2_seg  = s2_op.seg[seg_b-1:0];
  assign s2_bit  = s2_op.bit_id[bit_b-1:0];

  always_comb
  begin
    seg_nxt         = seg_q[s2_seg];
    seg_nxt[s2_bit] = |(s2_entry.sticky & s2_entry.int_en); // Channel pending
    irq_nxt         = 1'b0;
    for (int i = 0; i < seg_n; i++)
    begin
      irq_nxt |= (s2_valid && (s2_seg == seg_b'(i))) ? |seg_nxt : |seg_q[i];
    end
  end

  assign ram_we    = s2_valid;
  assign ram_waddr = s2_addr;
  assign ram_wdata = s2_entry;
  assign res_valid = s2_valid;

  always_comb
  begin
    res          = '0;
    res.opcode   = s2_op.opcode;
    res.seg      = seg_b_max'(s2_seg); // Upper id bits zero
    res.bit_id   = bit_b_max'(s2_bit);
    res.entry    = s2_entry;
    res.seg_word = seg_nxt;
  end

  always_ff @(posedge iclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
      irq      <= 1'b0;
      for (int i = 0; i < seg_n; i++)
      begin
        seg_q[i] <= '0;
      end
    end
    else
    begin
      s1_valid <= op_valid;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
      irq      <= irq_nxt;
      if (s2_valid)
      begin
        seg_q[s2_seg] <= seg_nxt;
      end
    end
  end

  // Pipeline payload
  always_ff @(posedge iclk)
  begin
    s1_op    <= op;
    s2_op    <= s1_op;
    s2_entry <= nxt;
    s3_addr  <= s2_addr;
    s3_entry <= s2_entry;
  end

  a_opcode_known: assert property (@(posedge iclk) disable iff (!arst_n)
    op_valid |-> (op.opcode inside {op_event, op_read, op_set_en, op_clr_sticky, op_init}));

endmodule

// File: logic/intr_fmt_pkg.sv
// Flag fields fixed at 4 bits; users pick seg_b up to 3 and bit_b up to 4, upper id bits stay zero
package intr_fmt_pkg;
  import intr_ctrl_pkg::*;

  localparam int flag_w    = 4;              // Sticky, status, enable, change
  localparam int seg_b_max = 3;              // Widest segment id
  localparam int bit_b_max = 4;              // Widest bit id
  localparam int bit_max   = 1 << bit_b_max; // Summary word width

  ////////////////////
  // Channel table word

  // int_en on top, sticky at the bottom
  typedef struct packed {
    logic [flag_w-1:0] int_en;
    logic [flag_w-1:0] status;
    logic [flag_w-1:0] sticky;
  } intr_entry_t;

  // One operation toward the engine
  typedef struct packed {
    intr_opcode_e         opcode;
    logic [seg_b_max-1:0] seg;
    logic [bit_b_max-1:0] bit_id;
    logic [flag_w-1:0]    sticky_req;  // Sticky bits to set
    logic [flag_w-1:0]    status;      // New status value
    logic [flag_w-1:0]    status_mask; // Status bits to take, also enable or clear mask
    logic [flag_w-1:0]    change_en;   // Status change sets sticky
  } intr_op_t;

  // Result two cycles after accept
  typedef struct packed {
    intr_opcode_e         opcode;
    logic [seg_b_max-1:0] seg;
    logic [bit_b_max-1:0] bit_id;
    intr_entry_t          entry;    // Entry after the operation
    logic [bit_max-1:0]   seg_word; // Updated pending word of the segment
  } intr_result_t;

endpackage

// File: logic/intr_host_port.sv
// Host must hold req and command until ack, and drop req before the next one; rsp valid with ack
module intr_host_port
  import intr_ctrl_pkg::*;
  import intr_fmt_pkg::*;
#(
  parameter int seg_b = 2,
  parameter int bit_b = 3
) (
  input  logic              iclk,
  input  logic              arst_n,
  input  logic              host_req,
  input  host_cmd_e         host_cmd,
  input  logic [seg_b-1:0]  host_seg,
  input  logic [bit_b-1:0]  host_bit,
  input  logic [flag_w-1:0] host_mask,
  input  logic              host_grant,
  input  logic              res_valid,
  input  intr_result_t      res,
  output logic              host_ack,
  output intr_result_t      host_rsp,
  output logic              host_op_valid,
  output intr_op_t          host_op
);

  typedef enum logic [1:0] {h_idle, h_issue, h_wait, h_ack} hp_state_e;

  hp_state_e    state_q;
  hp_state_e    state_nxt;
  logic         gnt_q; // Grant one cycle back
  logic         due_q; // Result of the granted op on res now
  intr_opcode_e opc;

  always_comb
  begin
    case (host_cmd)
      cmd_read:       opc = op_read;
      cmd_set_en:     opc = op_set_en;
      cmd_clr_sticky: opc = op_clr_sticky;
      default:        opc = op_read;
    endcase
  end

  // Built live from the held command
  always_comb
  begin
    host_op             = '0;
    host_op.opcode      = opc;
    host_op.seg         = seg_b_max'(host_seg);
    host_op.bit_id      = bit_b_max'(host_bit);
    host_op.status_mask = host_mask;
  end

  assign host_op_valid = (state_q == h_issue);
  assign host_ack      = (state_q == h_ack);

  ////////////////////
  // Four phase

  always_comb
  begin
    state_nxt = state_q;
    case (state_q)
      h_idle:  if (host_req) state_nxt = h_issue;
      h_issue: if (host_grant) state_nxt = h_wait;
      h_wait:  if (due_q && res_valid) state_nxt = h_ack;
      h_ack:   if (!host_req) state_nxt = h_idle; // Ack drops next cycle
      default: state_nxt = h_idle;
    endcase
  end

  always_ff @(posedge iclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q <= h_idle;
      gnt_q   <= 1'b0;
      due_q   <= 1'b0;
    end
    else
    begin
      state_q <= state_nxt;
      gnt_q   <= host_grant;
      due_q   <= gnt_q;
    end
  end

  always_ff @(posedge iclk)
  begin
    if ((state_q == h_wait) && due_q && res_valid)
    begin
      host_rsp <= res;
    end
  end

  a_ack_after_req: assert property (@(posedge iclk) disable iff (!arst_n)
    $rose(host_ack) |-> host_req);

endmodule

// File: logic/intr_restore_seq.sv
// Init sweep after reset; a restore edge seen while busy is held; host and events wait until idle
module intr_restore_seq
  import intr_ctrl_pkg::*;
  import intr_fmt_pkg::*;
#(
  parameter int seg_b = 2,
  parameter int bit_b = 3
) (
  input  logic                   iclk,
  input  logic                   arst_n,
  input  logic                   restore_req,
  input  logic                   host_op_valid,
  input  intr_op_t               host_op,
  input  logic                   ev_valid,
  input  intr_op_t               ev_op,
  input  logic                   res_valid,
  input  intr_result_t           res,
  input  logic [seg_b+bit_b-1:0] chan,
  input  logic                   last,
  output logic                   host_grant,
  output logic                   ev_ready,
  output logic                   eng_op_valid,
  output intr_op_t               eng_op,
  output logic                   cnt_clr,
  output logic                   cnt_step,
  output logic                   restore_busy
);

  localparam int aw = seg_b + bit_b;

  logic [2:0]        req_sync; // Two sync flops plus edge history
  logic              rise;
  logic              pend_q;   // Edge waiting for idle
  logic              start;
  seq_state_e        state_q;
  seq_state_e        state_nxt;
  logic [flag_w-1:0] stat_q;   // Status read back from the channel
  logic              hit;

  // Sequencer op for one channel, all bits watched
  function automatic intr_op_t chan_op(intr_opcode_e opc, logic [flag_w-1:0] status,
                                       logic [aw-1:0] ch);
    intr_op_t o;
    o             = '0;
    o.opcode      = opc;
    o.seg         = seg_b_max'(ch[aw-1:bit_b]);
    o.bit_id      = bit_b_max'(ch[bit_b-1:0]);
    o.status      = status;
    o.status_mask = '1;
    o.change_en   = '1;
    return o;
  endfunction

  assign rise  = req_sync[1] & ~req_sync[2];
  assign start = rise | pend_q;
  assign hit   = res_valid && (res.opcode == op_read) &&
                 (res.seg[seg_b-1:0] == chan[aw-1:bit_b]) &&
                 (res.bit_id[bit_b-1:0] == chan[bit_b-1:0]);
  assign restore_busy = (state_q != s_idle) || start;

  ////////////////////
  // Op source and walk

  always_comb
  begin
    state_nxt    = state_q;
    eng_op_valid = 1'b0;
    eng_op       = ev_op;
    host_grant   = 1'b0;
    ev_ready     = 1'b0;
    cnt_clr      = 1'b0;
    cnt_step     = 1'b0;
    case (state_q)
      s_init:
      begin
        eng_op_valid = 1'b1;
        eng_op       = chan_op(op_init, '0, chan);
        if (last)
          state_nxt = s_idle;
        else
          cnt_step = 1'b1;
      end
      s_idle:
      begin
        if (start)
        begin
          cnt_clr   = 1'b1; // Walk from channel 0
          state_nxt = s_read;
        end
        else if (host_op_valid)
        begin
          host_grant   = 1'b1; // Host beats events
          eng_op_valid = 1'b1;
          eng_op       = host_op;
        end
        else
        begin
          ev_ready     = 1'b1;
          eng_op_valid = ev_valid;
        end
      end
      s_read:
      begin
        eng_op_valid = 1'b1;
        eng_op       = chan_op(op_read, '0, chan);
        state_nxt    = s_wait;
      end
      s_wait:
      begin
        if (hit)
          state_nxt = s_clear;
      end
      s_clear:
      begin
        eng_op_valid = 1'b1;
        eng_op       = chan_op(op_event, '0, chan); // Active bits drop, sticky set
        state_nxt    = s_set;
      end
      s_set:
      begin
        eng_op_valid = 1'b1;
        eng_op       = chan_op(op_event, stat_q, chan); // Old status back
        if (last)
          state_nxt = s_idle;
        else
        begin
          cnt_step  = 1'b1;
          state_nxt = s_read;
        end
      end
      default: state_nxt = s_idle;
    endcase
  end

  always_ff @(posedge iclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      req_sync <= '0;
      pend_q   <= 1'b0;
      state_q  <= s_init;
    end
    else
    begin
      req_sync <= {req_sync[1:0], restore_req};
      pend_q   <= (pend_q | rise) && (state_q != s_idle); // Idle takes it at once
      state_q  <= state_nxt;
    end
  end

  always_ff @(posedge iclk)
  begin
    if ((state_q == s_wait) && hit)
    begin
      stat_q <= res.entry.status;
    end
  end

  // Read result lands by the second wait cycle
  a_wait_bounded: assert property (@(posedge iclk) disable iff (!arst_n)
    ((state_q == s_wait) && !hit) |=> hit);

endmodule

// File: logic/intr_scan_counter.sv
// Counts channel addresses upward from zero, clear beats step, wraps after the last channel
module intr_scan_counter #(
  parameter int seg_b = 2,
  parameter int bit_b = 3
) (
  input  logic                   iclk,
  input  logic                   arst_n,
  input  logic                   clr,
  input  logic                   step,
  output logic [seg_b+bit_b-1:0] chan,
  output logic                   last
);

  always_ff @(posedge iclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      chan <= '0; // Init sweep starts at channel 0
    end
    else if (clr)
    begin
      chan <= '0;
    end
    else if (step)
    begin
      chan <= chan + 1'b1;
    end
  end

  // Highest segment, highest bit
  assign last = &chan;

endmodule

// File: logic/intr_top.sv
// Channel table is internal; events stall on ev_ready during init, restore and host access
module intr_top
  import intr_ctrl_pkg::*;
  import intr_fmt_pkg::*;
#(
  parameter int seg_b = 2, // 4 segments
  parameter int bit_b = 3  // 8 channels per segment
) (
  input  logic              iclk,
  input  logic              arst_n,
  input  logic              restore_req,
  input  logic              ev_valid,
  output logic              ev_ready,
  input  intr_op_t          ev_op,
  input  logic              host_req,
  input  host_cmd_e         host_cmd,
  input  logic [seg_b-1:0]  host_seg,
  input  logic [bit_b-1:0]  host_bit,
  input  logic [flag_w-1:0] host_mask,
  output logic              host_ack,
  output intr_result_t      host_rsp,
  output logic              irq,
  output logic              restore_busy
);

  logic                   host_op_valid;
  intr_op_t               host_op;
  logic                   host_grant;
  logic                   eng_op_valid;
  intr_op_t               eng_op;
  logic                   res_valid;
  intr_result_t           res;
  logic                   ram_we;
  logic [seg_b+bit_b-1:0] ram_waddr;
  logic [seg_b+bit_b-1:0] ram_raddr;
  intr_entry_t            ram_wdata;
  intr_entry_t            ram_rdata;
  logic [seg_b+bit_b-1:0] chan;
  logic                   last;
  logic                   cnt_clr;
  logic                   cnt_step;

  intr_host_port #(.seg_b(seg_b), .bit_b(bit_b)) u_host (
    .iclk, .arst_n, .host_req, .host_cmd, .host_seg, .host_bit, .host_mask,
    .host_grant, .res_valid, .res, .host_ack, .host_rsp, .host_op_valid, .host_op
  );

  intr_restore_seq #(.seg_b(seg_b), .bit_b(bit_b)) u_seq (
    .iclk, .arst_n, .restore_req, .host_op_valid, .host_op, .ev_valid, .ev_op,
    .res_valid, .res, .chan, .last, .host_grant, .ev_ready, .eng_op_valid,
    .eng_op, .cnt_clr, .cnt_step, .restore_busy
  );

  intr_scan_counter #(.seg_b(seg_b), .bit_b(bit_b)) u_cnt (
    .iclk, .arst_n, .clr(cnt_clr), .step(cnt_step), .chan, .last
  );

  intr_event_engine #(.seg_b(seg_b), .bit_b(bit_b)) u_eng (
    .iclk, .arst_n, .op_valid(eng_op_valid), .op(eng_op), .ram_rdata,
    .ram_we, .ram_waddr, .ram_raddr, .ram_wdata, .res_valid, .res, .irq
  );

  intr_chan_ram #(.seg_b(seg_b), .bit_b(bit_b)) u_ram (
    .iclk, .we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
    .raddr(ram_raddr), .rdata(ram_rdata)
  );

endmodule

// File: tb/intr_tb.sv
// Runs intr_top at seg_b 2, bit_b 3; events and host access never overlap so model order is exact
module intr_tb
  import intr_ctrl_pkg::*;
  import intr_fmt_pkg::*;
();

  localparam int seg_b      = 2;
  localparam int bit_b      = 3;
  localparam int n_bit      = 1 << bit_b;
  localparam int n_seg      = 1 << seg_b;
  localparam int n_chan     = 1 << (seg_b + bit_b);
  localparam int n_rounds   = 20;
  localparam int ev_per     = 20; // Events per burst
  localparam int host_per   = 6;  // Host commands per round
  localparam int n_restores = 2;
  // Engine ops: bursts, host commands, four read sweeps, init, restore walks
  localparam int op_count   = n_rounds * (ev_per + host_per) + 4 * n_chan + n_chan
                              + n_restores * (3 * n_chan + 1);
  localparam int timeout_cycles = 20 * op_count;

  logic              iclk;
  logic              arst_n;
  logic              restore_req;
  logic              ev_valid;
  logic              ev_ready;
  intr_op_t          ev_op;
  logic              host_req;
  host_cmd_e         host_cmd;
  logic [seg_b-1:0]  host_seg;
  logic [bit_b-1:0]  host_bit;
  logic [flag_w-1:0] host_mask;
  logic              host_ack;
  intr_result_t      host_rsp;
  logic              irq;
  logic              restore_busy;

  intr_entry_t model_tab [n_chan]; // Reference channel table
  integer      seed;
  int          cycles;
  logic        ack_prev;

  tb_clkgen u_clk (.iclk);

  intr_top #(.seg_b(seg_b), .bit_b(bit_b)) dut (
    .iclk, .arst_n, .restore_req, .ev_valid, .ev_ready, .ev_op, .host_req, .host_cmd,
    .host_seg, .host_bit, .host_mask, .host_ack, .host_rsp, .irq, .restore_busy
  );

  ////////////////////
  // Reporting

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_entry(input string name, input intr_entry_t got, input intr_entry_t exp);
    if (got !== exp)
      report_failure($sformatf("error %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_seg(input string name, input logic [bit_max-1:0] got,
                           input logic [bit_max-1:0] exp);
    if (got !== exp)
      report_failure($sformatf("error %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_irq(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("error %s got %h expected %h", name, got, exp));
  endtask

  ////////////////////
  // Reference model

  // Bitwise form of the alarm rule
  function automatic intr_entry_t next_entry(intr_entry_t old, intr_op_t o);
    intr_entry_t e;
    e = old;
    case (o.opcode)
      op_event:
      begin
        for (int i = 0; i < flag_w; i++)
        begin
          if (o.status_mask[i])
            e.status[i] = o.status[i];
          if (o.sticky_req[i] || (o.change_en[i] && (e.status[i] != old.status[i])))
            e.sticky[i] = 1'b1; // Requested or watched change
        end
      end
      op_set_en: e.int_en = o.status_mask;
      op_clr_sticky:
      begin
        for (int i = 0; i < flag_w; i++)
        begin
          if (o.status_mask[i])
            e.sticky[i] = 1'b0;
        end
      end
      op_init: e = '0;
      default: e = old; // Read
    endcase
    return e;
  endfunction

  function automatic int chan_index(intr_op_t o);
    return int'(o.seg) * n_bit + int'(o.bit_id);
  endfunction

  task automatic apply_op(input intr_op_t o);
    model_tab[chan_index(o)] = next_entry(model_tab[chan_index(o)], o);
  endtask

  // Expected summary word, upper bits always zero
  function automatic logic [bit_max-1:0] pending_word(int s);
    logic [bit_max-1:0] w;
    w = '0;
    for (int b = 0; b < n_bit; b++)
    begin
      w[b] = |(model_tab[s * n_bit + b].sticky & model_tab[s * n_bit + b].int_en);
    end
    return w;
  endfunction

  function automatic logic any_pending();
    logic p;
    p = 1'b0;
    for (int s = 0; s < n_seg; s++)
    begin
      p |= |pending_word(s);
    end
    return p;
  endfunction

  ////////////////////
  // Stimulus

  // Half the events hit one hot channel for back to back hits
  task automatic make_event(input int hot, output intr_op_t o);
    int ch;
    o             = '0;
    ch            = ($random(seed) & 1) ? hot : ($random(seed) & (n_chan - 1));
    o.opcode      = op_event;
    o.seg         = seg_b_max'(ch / n_bit);
    o.bit_id      = bit_b_max'(ch % n_bit);
    o.status      = flag_w'($random(seed));
    o.status_mask = flag_w'($random(seed));
    o.change_en   = flag_w'($random(seed));
    o.sticky_req  = flag_w'($random(seed) & $random(seed)); // Sparse
  endtask

  task automatic send_event(input intr_op_t o);
    @(posedge iclk);
    ev_valid <= 1'b1;
    ev_op    <= o;
    do
    begin
      @(negedge iclk);
    end
    while (!ev_ready);
    apply_op(o); // Transfers on the coming edge
  endtask

  task automatic stop_events();
    @(posedge iclk);
    ev_valid <= 1'b0;
  endtask

  // One full four-phase access, result checked against the model
  task automatic host_access(input host_cmd_e cmd, input int ch, input logic [flag_w-1:0] mask);
    intr_op_t     o;
    intr_result_t rsp;
    @(posedge iclk);
    host_req  <= 1'b1;
    host_cmd  <= cmd;
    host_seg  <= seg_b'(ch / n_bit);
    host_bit  <= bit_b'(ch % n_bit);
    host_mask <= mask;
    do
    begin
      @(negedge iclk);
    end
    while (!host_ack);
    rsp = host_rsp;
    o   = '0;
    case (cmd)
      cmd_set_en:     o.opcode = op_set_en;
      cmd_clr_sticky: o.opcode = op_clr_sticky;
      default:        o.opcode = op_read;
    endcase
    o.seg         = seg_b_max'(ch / n_bit);
    o.bit_id      = bit_b_max'(ch % n_bit);
    o.status_mask = mask;
    apply_op(o);
    check_entry("host_rsp.entry", rsp.entry, model_tab[ch]);
    check_seg("host_rsp.seg_word", rsp.seg_word, pending_word(ch / n_bit));
    @(posedge iclk);
    host_req <= 1'b0;
    do
    begin
      @(negedge iclk);
    end
    while (host_ack); // Wait for ack low before the next req
  endtask

  task automatic read_all();
    for (int ch = 0; ch < n_chan; ch++)
    begin
      host_access(cmd_read, ch, '0);
    end
  endtask

  task automatic random_host();
    int r;
    int ch;
    r  = $random(seed);
    ch = $random(seed) & (n_chan - 1);
    case (r & 3)
      1:       host_access(cmd_set_en, ch, flag_w'($random(seed)));
      2:       host_access(cmd_clr_sticky, ch, flag_w'($random(seed)));
      default: host_access(cmd_read, ch, '0);
    endcase
  endtask

  task automatic idle_irq_check();
    repeat (5) @(negedge iclk); // Past the t+3 irq latency
    check_irq("irq", irq, any_pending());
  endtask

  // An event is held on the bus for the whole walk
  task automatic run_restore();
    intr_op_t held;
    make_event($random(seed) & (n_chan - 1), held);
    @(posedge iclk);
    restore_req <= 1'b1;
    do
    begin
      @(negedge iclk);
    end
    while (!restore_busy);
    @(posedge iclk);
    restore_req <= 1'b0;
    ev_valid    <= 1'b1;
    ev_op       <= held;
    do
    begin
      @(negedge iclk);
    end
    while (!ev_ready);
    for (int i = 0; i < n_chan; i++)
    begin
      model_tab[i].sticky |= model_tab[i].status; // Active status re-raised
    end
    apply_op(held);
    @(posedge iclk);
    ev_valid <= 1'b0;
  endtask

  ////////////////////
  // Monitors

  always @(negedge iclk)
  begin
    if (!arst_n)
    begin
      if (host_ack || irq)
        report_failure("host_ack or irq is high during reset");
    end
    else
    begin
      if (ev_ready && restore_busy)
        report_failure("ev_ready is high while restore_busy is high");
      if (host_ack && !ack_prev && !host_req)
        report_failure("host_ack rose while host_req was low");
      if (!host_ack && ack_prev && host_req)
        report_failure("host_ack fell while host_req was still high");
    end
    ack_prev = host_ack;
  end

  always @(posedge iclk)
  begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles)
      report_failure($sformatf("timeout, run not finished after %0d cycles", cycles));
  end

  ////////////////////
  // Test sequence

  initial
  begin
    int       hot;
    intr_op_t o;
    seed        = 32'h9fad_8d7f;
    cycles      = 0;
    ack_prev    = 1'b0;
    arst_n      = 1'b0;
    restore_req = 1'b0;
    ev_valid    = 1'b0;
    ev_op       = '0;
    host_req    = 1'b0;
    host_cmd    = cmd_read;
    host_seg    = '0;
    host_bit    = '0;
    host_mask   = '0;
    for (int i = 0; i < n_chan; i++)
    begin
      model_tab[i] = '0; // Init sweep result
    end
    repeat (10) @(posedge iclk);
    arst_n <= 1'b1;
    do
    begin
      @(negedge iclk);
    end
    while (restore_busy);
    check_irq("irq", irq, 1'b0);
    read_all(); // All zero after init
    for (int r = 0; r < n_rounds; r++)
    begin
      hot = $random(seed) & (n_chan - 1);
      for (int k = 0; k < ev_per; k++)
      begin
        make_event(hot, o);
        send_event(o);
      end
      stop_events();
      idle_irq_check();
      for (int k = 0; k < host_per; k++)
      begin
        random_host();
      end
      idle_irq_check();
      if ((r == 6) || (r == 13)) // Two restores mid run
      begin
        run_restore();
        read_all();
        idle_irq_check();
      end
    end
    read_all();
    idle_irq_check();
    $display("Everything OK");
    $finish;
  end

endmodule

// File: tb/tb_clkgen.sv
// Free running clock of period 4 time units, low at time 0, never stops on its own
module tb_clkgen #(
  parameter int half = 2 // Half period
) (
  output logic iclk
);

  initial
  begin
    iclk = 1'b0;
    forever
    begin
      #half iclk = ~iclk; // Toggle every half period
    end
  end

endmodule
